// ==== compile.f ====
+incdir+hw
hw/exec_pkg.sv
hw/exec_alu.sv
hw/next_pc_unit.sv
hw/exec_unit.sv
hw/exec_stage.sv
test/tb_exec_stage.sv

// ==== Bender.yml ====
package:
  name: exec_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/exec_pkg.sv
      - hw/exec_alu.sv
      - hw/next_pc_unit.sv
      - hw/exec_unit.sv
      - hw/exec_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_exec_stage.sv

// ==== test/tb_exec_stage.sv ====
`timescale 1ns/1ps
`include "exec_macros.svh"

module tb_exec_stage;

  import exec_pkg::*;

  localparam int CLK_PERIOD       = 4;
  localparam int RESET_CYCLES     = 10;
  localparam int CYCLES_PER_ENTRY = 64;

  typedef struct {
    string                 name;
    exec_req_t             req;
    logic [`EXEC_XLEN-1:0] mem_rdata;
    exec_resp_t            exp;
  } test_entry_t;

  logic                  clock;
  logic                  reset;
  exec_req_t             req;
  logic                  req_valid;
  logic                  req_ready;
  exec_resp_t            resp;
  logic                  resp_valid;
  logic                  resp_ready;
  logic [`EXEC_XLEN-1:0] mem_rdata;

  test_entry_t table_q[$];
  logic [31:0] lcg_state    = 32'hbb2c_6600;
  int          errors       = 0;
  int          checks       = 0;
  int          handoffs     = 0;
  bit          table_loaded = 1'b0;

  exec_stage i_dut (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .mem_rdata  (mem_rdata)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // independent count of output transfers
  always @(posedge clock) begin
    if (!reset && resp_valid && resp_ready) begin
      handoffs <= handoffs + 1;
    end
  end

  function automatic logic random_bit();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[16];  // bit 0 of the upper half
  endfunction

  function automatic void add_entry(input string name, input exec_req_t req_in,
                                    input logic [`EXEC_XLEN-1:0] mem_in, input exec_resp_t exp);
    test_entry_t e;
    e.name      = name;
    e.req       = req_in;
    e.mem_rdata = mem_in;
    e.exp       = exp;
    table_q.push_back(e);
  endfunction

  // unselected op2 fields carry filler
  function automatic void add_alu(input string name, input alu_op_e op, input op2_sel_e sel,
                                  input logic [`EXEC_XLEN-1:0] a, input logic [`EXEC_XLEN-1:0] b,
                                  input logic [`EXEC_XLEN-1:0] exp);
    logic [`EXEC_XLEN-1:0] src2;
    logic [`EXEC_XLEN-1:0] imm;
    logic [`EXEC_XLEN-1:0] csr;
    src2 = (sel == op2_src2) ? b : 32'h0bad_0002;
    imm  = (sel == op2_imm) ? b : 32'h0bad_0001;
    csr  = (sel == op2_csr) ? b : 32'h0bad_0004;
    add_entry(name, exec_req_t'{32'h1000, imm, a, src2, csr, npc_seq, wb_alu, sel, op,
                                1'b0, 1'b0},
              32'h0, exec_resp_t'{32'h1004, exp, exp, exp, 32'h0});
  endfunction

  function automatic void add_branch(input string name, input alu_op_e op,
                                     input logic [`EXEC_XLEN-1:0] a,
                                     input logic [`EXEC_XLEN-1:0] b, input logic taken);
    logic [`EXEC_XLEN-1:0] flag;
    flag = `EXEC_XLEN'(taken);
    add_entry(name, exec_req_t'{32'h4000, 32'h40, a, b, 32'h0bad_0004, npc_branch, wb_alu,
                                op2_src2, op, 1'b0, 1'b0},
              32'h0, exec_resp_t'{taken ? 32'h4040 : 32'h4004, flag, flag, flag, 32'h0});
  endfunction

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s expected %b actual %b", name, what, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input exec_resp_t exp, input exec_resp_t act);
    string fields [5] = '{"csr_wdata2", "csr_wdata1", "r_wdata", "alu_result", "npc"};
    checks++;
    for (int k = 0; k < 5; k++) begin
      if (act[k*`EXEC_XLEN +: `EXEC_XLEN] !== exp[k*`EXEC_XLEN +: `EXEC_XLEN]) begin
        errors++;
        $display("mismatch %s %s expected %h actual %h", name, fields[k],
                 exp[k*`EXEC_XLEN +: `EXEC_XLEN], act[k*`EXEC_XLEN +: `EXEC_XLEN]);
      end
    end
  endtask

  function automatic void load_table();
    add_alu("add_src2", alu_add, op2_src2, 32'd5, 32'd7, 32'd12);
    add_alu("add_csr", alu_add, op2_csr, 32'h100, 32'h23, 32'h123);
    add_alu("sub_imm", alu_sub, op2_imm, 32'd0, 32'd1, 32'hffff_ffff);
    add_alu("xor_src2", alu_xor, op2_src2, 32'hff00_ff00, 32'h0ff0_0ff0, 32'hf0f0_f0f0);
    add_alu("or_imm", alu_or, op2_imm, 32'h1234_0000, 32'h0000_5678, 32'h1234_5678);
    add_alu("and_csr", alu_and, op2_csr, 32'hffff_0000, 32'h0ff0_0ff0, 32'h0ff0_0000);
    add_alu("sll_imm", alu_sll, op2_imm, 32'h1, 32'h25, 32'h20);  // shamt is 5
    add_alu("srl_src2", alu_srl, op2_src2, 32'h8000_0000, 32'd4, 32'h0800_0000);
    add_alu("sra_src2", alu_sra, op2_src2, 32'h8000_0000, 32'd4, 32'hf800_0000);
    add_alu("slt_src2", alu_slt, op2_src2, 32'hffff_ffff, 32'd1, 32'd1);
    add_alu("sltu_src2", alu_sltu, op2_src2, 32'hffff_ffff, 32'd1, 32'd0);
    add_alu("sltu_imm", alu_sltu, op2_imm, 32'd1, 32'hffff_ffff, 32'd1);
    add_branch("beq_taken", alu_beq, 32'd5, 32'd5, 1'b1);
    add_branch("beq_not", alu_beq, 32'd5, 32'd6, 1'b0);
    add_branch("bne_taken", alu_bne, 32'd5, 32'd6, 1'b1);
    add_branch("bne_not", alu_bne, 32'd5, 32'd5, 1'b0);
    add_branch("blt_taken", alu_blt, 32'hffff_ffff, 32'd1, 1'b1);
    add_branch("blt_not", alu_blt, 32'd1, 32'hffff_ffff, 1'b0);
    add_branch("bge_taken", alu_bge, 32'd1, 32'hffff_ffff, 1'b1);
    add_branch("bge_not", alu_bge, 32'hffff_ffff, 32'd1, 1'b0);
    add_branch("bltu_taken", alu_bltu, 32'd1, 32'hffff_ffff, 1'b1);
    add_branch("bltu_not", alu_bltu, 32'hffff_ffff, 32'd1, 1'b0);
    add_branch("bgeu_taken", alu_bgeu, 32'hffff_ffff, 32'd1, 1'b1);
    add_branch("bgeu_not", alu_bgeu, 32'd1, 32'hffff_ffff, 1'b0);
    add_entry("jal", exec_req_t'{32'h2000, 32'h100, 32'h55, 32'h66, 32'h77,
              npc_jal, wb_link, op2_imm, alu_add, 1'b0, 1'b0}, 32'h0,
              exec_resp_t'{32'h2100, 32'h155, 32'h2004, 32'h155, 32'h0});
    add_entry("jalr", exec_req_t'{32'h2100, 32'h7, 32'h3000, 32'h0, 32'h0,
              npc_jalr, wb_link, op2_imm, alu_add, 1'b0, 1'b0}, 32'h0,
              exec_resp_t'{32'h3006, 32'h3007, 32'h2104, 32'h3007, 32'h0});
    add_entry("mret", exec_req_t'{32'h3000, 32'h0, 32'h0, 32'h0, 32'h8000_0040,
              npc_trap, wb_alu, op2_src2, alu_add, 1'b0, 1'b0}, 32'h0,
              exec_resp_t'{32'h8000_0040, 32'h0, 32'h0, 32'h0, 32'h0});
    add_entry("auipc", exec_req_t'{32'h5000, 32'h1234_5000, 32'h9, 32'h0, 32'h0,
              npc_seq, wb_auipc, op2_imm, alu_add, 1'b0, 1'b0}, 32'h0,
              exec_resp_t'{32'h5004, 32'h1234_5009, 32'h1234_a000, 32'h1234_5009, 32'h0});
    add_entry("load", exec_req_t'{32'h5004, 32'h8, 32'h6000, 32'h0, 32'h0,
              npc_seq, wb_load, op2_imm, alu_add, 1'b0, 1'b0}, 32'hcafe_f00d,
              exec_resp_t'{32'h5008, 32'h6008, 32'hcafe_f00d, 32'h6008, 32'h0});
    add_entry("csrrs", exec_req_t'{32'h5008, 32'h0, 32'h88, 32'h0, 32'h1800,
              npc_seq, wb_csr, op2_csr, alu_or, 1'b0, 1'b0}, 32'h0,
              exec_resp_t'{32'h500c, 32'h1888, 32'h1800, 32'h1888, 32'h0});
    add_entry("csrrc", exec_req_t'{32'h500c, 32'h0, 32'h000f_00ff, 32'h0, 32'h0000_0f0f,
              npc_seq, wb_csr, op2_csr, alu_andn, 1'b0, 1'b0}, 32'h0,
              exec_resp_t'{32'h5010, 32'h000f_00f0, 32'h0000_0f0f, 32'h000f_00f0, 32'h0});
    add_entry("ecall", exec_req_t'{32'h6000, 32'h0, 32'h0, 32'h0, 32'h8000_0100,
              npc_trap, wb_alu, op2_src2, alu_add, 1'b1, 1'b1}, 32'h0,
              exec_resp_t'{32'h8000_0100, 32'h0, 32'h0, 32'd11, 32'h6000});
  endfunction

  initial begin
    test_entry_t e;
    logic        done;
    clock      = 1'b0;
    reset      = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b0;
    mem_rdata  = '0;
    load_table();
    table_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    foreach (table_q[i]) begin
      e = table_q[i];
      req       <= e.req;
      req_valid <= 1'b1;
      mem_rdata <= e.mem_rdata;
      @(negedge clock);
      check_flag(e.name, "req_ready idle", 1'b1, req_ready);
      check_flag(e.name, "resp_valid idle", 1'b0, resp_valid);
      while (!req_ready) @(negedge clock);
      @(posedge clock);  // accept edge
      req_valid  <= 1'b0;
      req        <= '0;  // result must come from the held copy
      resp_ready <= random_bit();
      done = 1'b0;
      while (!done) begin
        @(negedge clock);
        check_flag(e.name, "resp_valid held", 1'b1, resp_valid);
        check_flag(e.name, "req_ready busy", 1'b0, req_ready);
        check_resp(e.name, e.exp, resp);
        done = resp_ready;
        @(posedge clock);
        resp_ready <= done ? 1'b0 : random_bit();
      end
    end
    req_valid <= 1'b0;
    @(negedge clock);
    checks++;
    if (handoffs != table_q.size()) begin
      errors++;
      $display("mismatch handoff_count expected %0d actual %0d", table_q.size(), handoffs);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (table_loaded);
    #(table_q.size() * CYCLES_PER_ENTRY * CLK_PERIOD);
    $display("timeout, the stage stopped completing requests, errors: %0d", errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== hw/exec_stage.sv ====
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  exec_pkg::exec_req_t    req,
  input  logic                   req_valid,
  output logic                   req_ready,
  output exec_pkg::exec_resp_t   resp,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  input  logic [`EXEC_XLEN-1:0]  mem_rdata
);

  import exec_pkg::*;

  alu_op_e               alu_op;
  npc_sel_e              held_npc_sel;
  logic [`EXEC_XLEN-1:0] operand_a;
  logic [`EXEC_XLEN-1:0] operand_b;
  logic [`EXEC_XLEN-1:0] alu_result;
  logic [`EXEC_XLEN-1:0] held_pc;
  logic [`EXEC_XLEN-1:0] held_imm;
  logic [`EXEC_XLEN-1:0] held_csr_src;
  logic [`EXEC_XLEN-1:0] npc;
  logic [`EXEC_XLEN-1:0] link_pc;
  logic [`EXEC_XLEN-1:0] target_pc;

  exec_unit i_exec_unit (
    .clock        (clock),
    .reset        (reset),
    .req_valid    (req_valid),
    .resp_ready   (resp_ready),
    .req          (req),
    .mem_rdata    (mem_rdata),
    .alu_result   (alu_result),
    .npc          (npc),
    .link_pc      (link_pc),
    .target_pc    (target_pc),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .alu_op       (alu_op),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .held_pc      (held_pc),
    .held_imm     (held_imm),
    .held_csr_src (held_csr_src),
    .held_npc_sel (held_npc_sel),
    .resp         (resp)
  );

  exec_alu i_exec_alu (
    .op        (alu_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (alu_result)
  );

  next_pc_unit i_next_pc_unit (
    .pc         (held_pc),
    .imm        (held_imm),
    .csr_src    (held_csr_src),
    .alu_result (alu_result),
    .npc_sel    (held_npc_sel),
    .npc        (npc),
    .link_pc    (link_pc),
    .target_pc  (target_pc)
  );

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req_valid,
  input  logic                   resp_ready,
  input  exec_pkg::exec_req_t    req,
  input  logic [`EXEC_XLEN-1:0]  mem_rdata,
  input  logic [`EXEC_XLEN-1:0]  alu_result,
  input  logic [`EXEC_XLEN-1:0]  npc,
  input  logic [`EXEC_XLEN-1:0]  link_pc,
  input  logic [`EXEC_XLEN-1:0]  target_pc,
  output logic                   req_ready,
  output logic                   resp_valid,
  output exec_pkg::alu_op_e      alu_op,
  output logic [`EXEC_XLEN-1:0]  operand_a,
  output logic [`EXEC_XLEN-1:0]  operand_b,
  output logic [`EXEC_XLEN-1:0]  held_pc,
  output logic [`EXEC_XLEN-1:0]  held_imm,
  output logic [`EXEC_XLEN-1:0]  held_csr_src,
  output exec_pkg::npc_sel_e     held_npc_sel,
  output exec_pkg::exec_resp_t   resp
);

  import exec_pkg::*;

  exec_req_t             req_q;
  logic [`EXEC_XLEN-1:0] operand_b_q;
  logic [`EXEC_XLEN-1:0] operand_b_sel;
  logic                  accept;
  logic                  handoff;

  assign accept  = req_valid & req_ready;
  assign handoff = resp_valid & resp_ready;

  always_comb begin
    case (req.op2_sel)
      op2_src2: begin
        operand_b_sel = req.src2;
      end
      op2_imm: begin
        operand_b_sel = req.imm;  // most i-type
      end
      op2_csr: begin
        operand_b_sel = req.csr_src;
      end
      default: begin
        operand_b_sel = '0;
      end
    endcase
  end

  // one instruction in flight at a time
  always_ff @(posedge clock) begin
    if (reset) begin
      req_ready  <= 1'b1;
      resp_valid <= 1'b0;
    end else if (accept) begin
      req_ready  <= 1'b0;
      resp_valid <= 1'b1;
    end else if (handoff) begin
      req_ready  <= 1'b1;
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q       <= req;
      operand_b_q <= operand_b_sel;
    end
  end

  assign alu_op       = req_q.alu_op;
  assign operand_a    = req_q.src1;
  assign operand_b    = operand_b_q;
  assign held_pc      = req_q.pc;
  assign held_imm     = req_q.imm;
  assign held_csr_src = req_q.csr_src;
  assign held_npc_sel = req_q.npc_sel;

  assign resp.npc        = npc;
  assign resp.alu_result = alu_result;

  always_comb begin
    case (req_q.wb_sel)
      wb_alu: begin
        resp.r_wdata = alu_result;
      end
      wb_link: begin
        resp.r_wdata = link_pc;
      end
      wb_auipc: begin
        resp.r_wdata = target_pc;
      end
      wb_load: begin
        resp.r_wdata = mem_rdata;  // live from memory
      end
      wb_csr: begin
        resp.r_wdata = req_q.csr_src;
      end
      default: begin
        resp.r_wdata = '0;
      end
    endcase
  end

  assign resp.csr_wdata1 = req_q.csr_cause_sel ? `EXEC_XLEN'(`EXEC_ECALL_CAUSE) : alu_result;
  assign resp.csr_wdata2 = req_q.csr_epc_sel ? req_q.pc : '0;  // mepc on ecall

  a_ready_valid_excl: assert property (@(posedge clock) disable iff (reset)
    !(req_ready && resp_valid));

  a_resp_hold: assert property (@(posedge clock) disable iff (reset)
    (resp_valid && !resp_ready) |=> resp_valid);

  // latched bundle fully defined
  a_req_known: assert property (@(posedge clock) disable iff (reset)
    accept |-> !$isunknown(req));

endmodule

// ==== hw/next_pc_unit.sv ====
`timescale 1ns/1ps
`include "exec_macros.svh"

module next_pc_unit (
  input  logic [`EXEC_XLEN-1:0]  pc,
  input  logic [`EXEC_XLEN-1:0]  imm,
  input  logic [`EXEC_XLEN-1:0]  csr_src,
  input  logic [`EXEC_XLEN-1:0]  alu_result,
  input  exec_pkg::npc_sel_e     npc_sel,
  output logic [`EXEC_XLEN-1:0]  npc,
  output logic [`EXEC_XLEN-1:0]  link_pc,
  output logic [`EXEC_XLEN-1:0]  target_pc
);

  import exec_pkg::*;

  assign link_pc   = pc + `EXEC_XLEN'(`EXEC_PC_STEP);
  assign target_pc = pc + imm;  // jal and branch target

  always_comb begin
    npc = '0;
    case (npc_sel)
      npc_seq: begin
        npc = link_pc;
      end
      npc_jal: begin
        npc = target_pc;
      end
      npc_jalr: begin
        npc = alu_result & ~`EXEC_XLEN'(1);  // src1+imm, lsb cleared
      end
      npc_branch: begin
        npc = alu_result[0] ? target_pc : link_pc;
      end
      npc_trap: begin
        npc = csr_src;  // mtvec or mepc
      end
      default: begin
        npc = '0;
      end
    endcase
  end

endmodule

// ==== hw/exec_alu.sv ====
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_alu (
  input  exec_pkg::alu_op_e      op,
  input  logic [`EXEC_XLEN-1:0]  operand_a,
  input  logic [`EXEC_XLEN-1:0]  operand_b,
  output logic [`EXEC_XLEN-1:0]  result
);

  import exec_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = operand_b[4:0];
  assign eq    = (operand_a == operand_b);
  assign lt_s  = ($signed(operand_a) < $signed(operand_b));
  assign lt_u  = (operand_a < operand_b);

  always_comb begin
    result = '0;
    case (op)
      alu_add: begin
        result = operand_a + operand_b;
      end
      alu_sub: begin
        result = operand_a - operand_b;
      end
      alu_sll: begin
        result = operand_a << shamt;
      end
      alu_srl: begin
        result = operand_a >> shamt;
      end
      alu_sra: begin
        result = $signed(operand_a) >>> shamt;  // keeps sign bit
      end
      alu_xor: begin
        result = operand_a ^ operand_b;
      end
      alu_or: begin
        result = operand_a | operand_b;
      end
      alu_and: begin
        result = operand_a & operand_b;
      end
      alu_andn: begin
        result = operand_a & ~operand_b;  // csrrc
      end
      alu_slt: begin
        result[0] = lt_s;
      end
      alu_sltu: begin
        result[0] = lt_u;
      end
      // branch codes leave the taken flag in bit 0
      alu_beq: begin
        result[0] = eq;
      end
      alu_bne: begin
        result[0] = ~eq;
      end
      alu_blt: begin
        result[0] = lt_s;
      end
      alu_bge: begin
        result[0] = ~lt_s;
      end
      alu_bltu: begin
        result[0] = lt_u;
      end
      alu_bgeu: begin
        result[0] = ~lt_u;
      end
      default: begin
        result = '0;  // unknown code
      end
    endcase
  end

endmodule

// ==== hw/exec_pkg.sv ====
`include "exec_macros.svh"

package exec_pkg;

  typedef enum logic [2:0] {
    npc_seq    = 3'd0,
    npc_jal    = 3'd1,
    npc_jalr   = 3'd2,
    npc_branch = 3'd3,
    npc_trap   = 3'd4  // ecall and mret
  } npc_sel_e;

  typedef enum logic [2:0] {
    wb_alu   = 3'd0,
    wb_link  = 3'd1,  // pc+4 for jal and jalr
    wb_auipc = 3'd2,  // pc+imm
    wb_load  = 3'd3,
    wb_csr   = 3'd4   // old csr value
  } wb_sel_e;

  typedef enum logic [1:0] {
    op2_src2 = 2'd0,
    op2_imm  = 2'd1,
    op2_csr  = 2'd2   // csrrs and csrrc
  } op2_sel_e;

  typedef enum logic [`EXEC_ALU_OP_W-1:0] {
    alu_add  = 8'h00,
    alu_sub  = 8'h01,
    alu_sll  = 8'h02,
    alu_slt  = 8'h03,
    alu_sltu = 8'h04,
    alu_xor  = 8'h05,
    alu_srl  = 8'h06,
    alu_sra  = 8'h07,
    alu_or   = 8'h08,
    alu_and  = 8'h09,
    alu_beq  = 8'h10,
    alu_bne  = 8'h11,
    alu_blt  = 8'h12,
    alu_bge  = 8'h13,
    alu_bltu = 8'h14,
    alu_bgeu = 8'h15,
    alu_andn = 8'h20   // csrrc clears bits
  } alu_op_e;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0] pc;
    logic [`EXEC_XLEN-1:0] imm;
    logic [`EXEC_XLEN-1:0] src1;
    logic [`EXEC_XLEN-1:0] src2;
    logic [`EXEC_XLEN-1:0] csr_src;
    npc_sel_e              npc_sel;
    wb_sel_e               wb_sel;
    op2_sel_e              op2_sel;
    alu_op_e               alu_op;
    logic                  csr_cause_sel;
    logic                  csr_epc_sel;
  } exec_req_t;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0] npc;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] r_wdata;
    logic [`EXEC_XLEN-1:0] csr_wdata1;
    logic [`EXEC_XLEN-1:0] csr_wdata2;
  } exec_resp_t;

endpackage

// ==== hw/exec_macros.svh ====
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// data and address width
`define EXEC_XLEN 32

// sequential pc increment
`define EXEC_PC_STEP 4

// width of the alu opcode field
`define EXEC_ALU_OP_W 8

// mcause value for ecall from m-mode
`define EXEC_ECALL_CAUSE 11

`endif
